/* include/sts_params.svh */
`ifndef STS_PARAMS_SVH
`define STS_PARAMS_SVH

// status word fields
`define STS_ARITH_W 8
`define STS_MODE_W 7
`define STS_MASK_W 10

// mask + mode + arith
`define STS_WORD_W 25

// status stack geometry
`define STS_DEPTH 7
`define STS_PTR_W 3

`endif

/* rtl/stsTypesPkg.sv */
`default_nettype none

`include "sts_params.svh"

package stsTypesPkg;

  // AZ in bit 0 up to AC in bit 3; the upper nibble is kept but never tested
  typedef struct packed {
    logic [`STS_ARITH_W-5:0] spare;
    logic ac;                                 // carry
    logic av;                                 // overflow
    logic an;                                 // negative
    logic az;                                 // zero
  } arithStatT;

  typedef logic [`STS_MODE_W-1:0] modeStatT;

  typedef logic [`STS_MASK_W-1:0] intMaskT;

  typedef struct packed {
    intMaskT mask;                            // top 10 bits
    modeStatT mode;
    arithStatT arith;                         // low 8 bits
  } stsWordT;

  typedef logic [`STS_PTR_W-1:0] stkPtrT;

endpackage

`default_nettype wire

/* rtl/stsCmdPkg.sv */
`default_nettype none

package stsCmdPkg;

  // host command opcodes
  typedef enum logic [2:0] {
    OP_NOP      = 3'd0,
    OP_WRARITH  = 3'd1,
    OP_WRMODE   = 3'd2,
    OP_WRMASK   = 3'd3,
    OP_PUSH     = 3'd4,
    OP_POP      = 3'd5,                       // also return from interrupt
    OP_INTENTRY = 3'd6
  } stsOpE;

  // condition codes on the arithmetic flags
  typedef enum logic [3:0] {
    COND_EQ     = 4'd0,
    COND_NE     = 4'd1,
    COND_LT     = 4'd2,
    COND_GE     = 4'd3,
    COND_GT     = 4'd4,
    COND_LE     = 4'd5,
    COND_AV     = 4'd6,
    COND_NOTAV  = 4'd7,
    COND_AC     = 4'd8,
    COND_NOTAC  = 4'd9,
    COND_ALWAYS = 4'd10
  } condE;

endpackage

`default_nettype wire

/* rtl/stsCmdDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module stsCmdDecode (
  input  logic             STSCLK,
  input  logic             T_RST,
  input  logic             cmdValid,
  input  stsCmdPkg::stsOpE cmdOp,
  input  logic [9:0]       cmdData,
  output logic             wrArith,
  output logic             wrMode,
  output logic             wrMask,
  output logic [9:0]       wrData,
  output logic             pushEn,
  output logic             popEn,
  output logic             restoreEn,
  output logic             clrMask
);

  import stsCmdPkg::*;

  logic arithNext, modeNext, maskNext;
  logic pushNext, popNext, clrNext;

  always_comb begin
    arithNext = 1'b0;
    modeNext  = 1'b0;
    maskNext  = 1'b0;
    pushNext  = 1'b0;
    popNext   = 1'b0;
    clrNext   = 1'b0;
    if (cmdValid) begin
      case (cmdOp)
        OP_WRARITH:  arithNext = 1'b1;
        OP_WRMODE:   modeNext  = 1'b1;
        OP_WRMASK:   maskNext  = 1'b1;
        OP_PUSH:     pushNext  = 1'b1;
        OP_POP:      popNext   = 1'b1;
        OP_INTENTRY: begin
          pushNext = 1'b1;                    // save word, then drop the mask
          clrNext  = 1'b1;
        end
        default: ;                            // nop
      endcase
    end
  end

  always_ff @(posedge STSCLK or posedge T_RST) begin
    if (T_RST) begin
      wrArith   <= 1'b0;
      wrMode    <= 1'b0;
      wrMask    <= 1'b0;
      pushEn    <= 1'b0;
      popEn     <= 1'b0;
      restoreEn <= 1'b0;
      clrMask   <= 1'b0;
    end else begin
      wrArith   <= arithNext;
      wrMode    <= modeNext;
      wrMask    <= maskNext;
      pushEn    <= pushNext;
      popEn     <= popNext;
      restoreEn <= popNext;                   // pop reloads the registers
      clrMask   <= clrNext;
    end
  end

  always_ff @(posedge STSCLK) begin
    if (cmdValid) begin
      wrData <= cmdData;
    end
  end

endmodule

`default_nettype wire

/* rtl/statusRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module statusRegs (
  input  logic                   STSCLK,
  input  logic                   T_RST,
  input  logic                   wrArith,
  input  logic                   wrMode,
  input  logic                   wrMask,
  input  logic [9:0]             wrData,
  input  logic                   restoreEn,
  input  logic                   clrMask,
  input  stsTypesPkg::stsWordT   topWord,
  input  logic                   stkEmpty,
  output stsTypesPkg::arithStatT arithStat,
  output stsTypesPkg::modeStatT  modeStat,
  output stsTypesPkg::intMaskT   intMask,
  output stsTypesPkg::stsWordT   curWord
);

  import stsTypesPkg::*;

  logic doRestore;

  assign doRestore = restoreEn && !stkEmpty;  // nothing to restore from an empty stack

  always_ff @(posedge STSCLK or posedge T_RST) begin
    if (T_RST) begin
      arithStat <= '0;
      modeStat  <= '0;
      intMask   <= '0;
    end else if (doRestore) begin
      arithStat <= topWord.arith;
      modeStat  <= topWord.mode;
      intMask   <= topWord.mask;
    end else begin
      if (wrArith) begin
        arithStat <= arithStatT'(wrData[$bits(arithStatT)-1:0]);
      end
      if (wrMode) begin
        modeStat <= modeStatT'(wrData[$bits(modeStatT)-1:0]);
      end
      // on interrupt entry the stack takes the old word on this same edge
      if (wrMask) begin
        intMask <= intMaskT'(wrData);
      end else if (clrMask) begin
        intMask <= '0;
      end
    end
  end

  assign curWord = '{mask: intMask, mode: modeStat, arith: arithStat};

endmodule

`default_nettype wire

/* rtl/stackMem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sts_params.svh"

module stackMem (
  input  logic                   STSCLK,
  input  logic                   we,
  input  logic [`STS_PTR_W-1:0]  wrAddr,
  input  logic [`STS_WORD_W-1:0] wrWord,
  input  logic [`STS_PTR_W-1:0]  rdAddr,
  output logic [`STS_WORD_W-1:0] rdWord
);

  logic [`STS_WORD_W-1:0] mem [`STS_DEPTH];

  always_ff @(posedge STSCLK) begin
    if (we) begin
      mem[wrAddr] <= wrWord;
    end
  end

  // the empty pointer lies past the last entry
  assign rdWord = (rdAddr < `STS_PTR_W'(`STS_DEPTH)) ? mem[rdAddr] : '0;

endmodule

`default_nettype wire

/* rtl/statusStack.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sts_params.svh"

module statusStack (
  input  logic                 STSCLK,
  input  logic                 T_RST,
  input  logic                 pushEn,
  input  logic                 popEn,
  input  stsTypesPkg::stsWordT curWord,
  output stsTypesPkg::stsWordT topWord,
  output logic                 stkFull,
  output logic                 stkEmpty,
  output logic                 stkHas1,
  output logic                 stkOvf
);

  import stsTypesPkg::*;

  stkPtrT ptr;
  stkPtrT ptrInc;
  stkPtrT ptrDec;
  logic   doPush;
  logic   doPop;

  // pointer counts down to empty; 7 means no entries
  assign stkEmpty = (ptr == stkPtrT'(`STS_DEPTH));
  assign stkFull  = (ptr == stkPtrT'(`STS_DEPTH - 1));
  assign stkHas1  = (ptr == '0);

  assign doPush = pushEn && !stkFull;
  assign doPop  = popEn && !stkEmpty;

  assign ptrInc = ptr + 1'b1;                 // wraps 7 -> 0 on first push
  assign ptrDec = ptr - 1'b1;

  always_ff @(posedge STSCLK or posedge T_RST) begin
    if (T_RST) begin
      ptr <= stkPtrT'(`STS_DEPTH);
    end else if (doPush) begin
      ptr <= ptrInc;
    end else if (doPop) begin
      ptr <= ptrDec;
    end
  end

  always_ff @(posedge STSCLK or posedge T_RST) begin
    if (T_RST) begin
      stkOvf <= 1'b0;
    end else if ((pushEn && stkFull) || (popEn && stkEmpty)) begin
      stkOvf <= 1'b1;                         // sticky
    end
  end

  stackMem stackMem (
    .STSCLK (STSCLK),
    .we     (doPush),
    .wrAddr (ptrInc),
    .wrWord (curWord),
    .rdAddr (ptr),
    .rdWord (topWord)
  );

endmodule

`default_nettype wire

/* rtl/stsCondEval.sv */
`timescale 1ns/1ps
`default_nettype none

module stsCondEval (
  input  logic                   STSCLK,
  input  logic                   T_RST,
  input  stsTypesPkg::arithStatT arithStat,
  input  stsCmdPkg::condE        condSel,
  output logic                   condTrue
);

  import stsCmdPkg::*;

  logic condNext;

  always_comb begin
    case (condSel)
      COND_EQ:     condNext = arithStat.az;
      COND_NE:     condNext = !arithStat.az;
      COND_LT:     condNext = arithStat.an;
      COND_GE:     condNext = !arithStat.an;
      COND_GT:     condNext = !(arithStat.az || arithStat.an);
      COND_LE:     condNext = arithStat.az || arithStat.an;
      COND_AV:     condNext = arithStat.av;
      COND_NOTAV:  condNext = !arithStat.av;
      COND_AC:     condNext = arithStat.ac;
      COND_NOTAC:  condNext = !arithStat.ac;
      COND_ALWAYS: condNext = 1'b1;
      default:     condNext = 1'b0;           // unused codes never true
    endcase
  end

  always_ff @(posedge STSCLK or posedge T_RST) begin
    if (T_RST) begin
      condTrue <= 1'b0;
    end else begin
      condTrue <= condNext;
    end
  end

endmodule

`default_nettype wire

/* rtl/stsSeqTop.sv */
`timescale 1ns/1ps
`default_nettype none

module stsSeqTop (
  input  logic                   STSCLK,
  input  logic                   T_RST,
  input  logic                   cmdValid,
  input  stsCmdPkg::stsOpE       cmdOp,
  input  logic [9:0]             cmdData,
  input  stsCmdPkg::condE        condSel,
  output stsTypesPkg::arithStatT arithStat,
  output stsTypesPkg::modeStatT  modeStat,
  output stsTypesPkg::intMaskT   intMask,
  output logic                   stkFull,
  output logic                   stkEmpty,
  output logic                   stkHas1,
  output logic                   stkOvf,
  output logic                   condTrue
);

  import stsTypesPkg::*;

  logic       wrArith;
  logic       wrMode;
  logic       wrMask;
  logic [9:0] wrData;
  logic       pushEn;
  logic       popEn;
  logic       restoreEn;
  logic       clrMask;
  stsWordT    curWord;
  stsWordT    topWord;

  stsCmdDecode stsCmdDecode (
    .STSCLK    (STSCLK),
    .T_RST     (T_RST),
    .cmdValid  (cmdValid),
    .cmdOp     (cmdOp),
    .cmdData   (cmdData),
    .wrArith   (wrArith),
    .wrMode    (wrMode),
    .wrMask    (wrMask),
    .wrData    (wrData),
    .pushEn    (pushEn),
    .popEn     (popEn),
    .restoreEn (restoreEn),
    .clrMask   (clrMask)
  );

  statusRegs statusRegs (
    .STSCLK    (STSCLK),
    .T_RST     (T_RST),
    .wrArith   (wrArith),
    .wrMode    (wrMode),
    .wrMask    (wrMask),
    .wrData    (wrData),
    .restoreEn (restoreEn),
    .clrMask   (clrMask),
    .topWord   (topWord),
    .stkEmpty  (stkEmpty),
    .arithStat (arithStat),
    .modeStat  (modeStat),
    .intMask   (intMask),
    .curWord   (curWord)
  );

  statusStack statusStack (
    .STSCLK   (STSCLK),
    .T_RST    (T_RST),
    .pushEn   (pushEn),
    .popEn    (popEn),
    .curWord  (curWord),
    .topWord  (topWord),
    .stkFull  (stkFull),
    .stkEmpty (stkEmpty),
    .stkHas1  (stkHas1),
    .stkOvf   (stkOvf)
  );

  stsCondEval stsCondEval (
    .STSCLK    (STSCLK),
    .T_RST     (T_RST),
    .arithStat (arithStat),
    .condSel   (condSel),
    .condTrue  (condTrue)
  );

endmodule

`default_nettype wire

/* bench/stsSeqTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sts_params.svh"

module stsSeqTb;

  import stsCmdPkg::*;

  localparam int ROW_MAX = 128;

  logic                    STSCLK;
  logic                    T_RST;
  logic                    cmdValid;
  stsOpE                   cmdOp;
  logic [9:0]              cmdData;
  condE                    condSel;
  logic [`STS_ARITH_W-1:0] arithStat;
  logic [`STS_MODE_W-1:0]  modeStat;
  logic [`STS_MASK_W-1:0]  intMask;
  logic                    stkFull;
  logic                    stkEmpty;
  logic                    stkHas1;
  logic                    stkOvf;
  logic                    condTrue;

  // stimulus table with one command per row
  string                   rowName [ROW_MAX];
  stsOpE                   rowOp [ROW_MAX];
  logic [9:0]              rowData [ROW_MAX];
  condE                    rowCond [ROW_MAX];
  logic                    rowIsReset [ROW_MAX];
  logic [`STS_ARITH_W-1:0] expArith [ROW_MAX];
  logic [`STS_MODE_W-1:0]  expMode [ROW_MAX];
  logic [`STS_MASK_W-1:0]  expMask [ROW_MAX];
  logic [3:0]              expFlags [ROW_MAX];    // full, empty, has1, ovf
  logic                    expCondTrue [ROW_MAX];
  int                      rowCount;

  // reference model state
  logic [`STS_ARITH_W-1:0] mArith;
  logic [`STS_MODE_W-1:0]  mMode;
  logic [`STS_MASK_W-1:0]  mMask;
  logic                    mOvf;
  logic [`STS_WORD_W-1:0]  stackModel [$];

  int errorCount;
  int checkCount;
  int cycleCount;
  int cycleLimit;

  stsSeqTop UUT (
    .STSCLK    (STSCLK),
    .T_RST     (T_RST),
    .cmdValid  (cmdValid),
    .cmdOp     (cmdOp),
    .cmdData   (cmdData),
    .condSel   (condSel),
    .arithStat (arithStat),
    .modeStat  (modeStat),
    .intMask   (intMask),
    .stkFull   (stkFull),
    .stkEmpty  (stkEmpty),
    .stkHas1   (stkHas1),
    .stkOvf    (stkOvf),
    .condTrue  (condTrue)
  );

  always #4 STSCLK = ~STSCLK;

  always @(posedge STSCLK) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      $display("Errors found");
      $finish;
    end
  end

  // flags bit 0 zero, 1 negative, 2 overflow, 3 carry
  function automatic logic expectedCond(input logic [`STS_ARITH_W-1:0] a, input condE c);
    case (c)
      COND_EQ:     return a[0];
      COND_NE:     return !a[0];
      COND_LT:     return a[1];
      COND_GE:     return !a[1];
      COND_GT:     return !(a[0] || a[1]);
      COND_LE:     return a[0] || a[1];
      COND_AV:     return a[2];
      COND_NOTAV:  return !a[2];
      COND_AC:     return a[3];
      COND_NOTAC:  return !a[3];
      COND_ALWAYS: return 1'b1;
      default:     return 1'b0;
    endcase
  endfunction

  task automatic recordRow(input string nm, input stsOpE op, input logic [9:0] data,
                           input condE cond, input logic isReset);
    rowName[rowCount]     = nm;
    rowOp[rowCount]       = op;
    rowData[rowCount]     = data;
    rowCond[rowCount]     = cond;
    rowIsReset[rowCount]  = isReset;
    expArith[rowCount]    = mArith;
    expMode[rowCount]     = mMode;
    expMask[rowCount]     = mMask;
    expFlags[rowCount]    = {stackModel.size() == `STS_DEPTH, stackModel.size() == 0,
                             stackModel.size() == 1, mOvf};
    expCondTrue[rowCount] = expectedCond(mArith, cond);
    rowCount = rowCount + 1;
  endtask

  task automatic addRow(input string nm, input stsOpE op, input logic [9:0] data,
                        input condE cond);
    logic [`STS_WORD_W-1:0] w;
    case (op)
      OP_WRARITH: mArith = data[`STS_ARITH_W-1:0];
      OP_WRMODE:  mMode = data[`STS_MODE_W-1:0];
      OP_WRMASK:  mMask = data;
      OP_PUSH, OP_INTENTRY: begin
        if (stackModel.size() == `STS_DEPTH) begin
          mOvf = 1'b1;
        end else begin
          stackModel.push_back({mMask, mMode, mArith});
        end
        if (op == OP_INTENTRY) begin
          mMask = '0;                              // old mask is already saved
        end
      end
      OP_POP: begin
        if (stackModel.size() == 0) begin
          mOvf = 1'b1;
        end else begin
          w = stackModel.pop_back();
          mMask  = w[`STS_WORD_W-1 -: `STS_MASK_W];
          mMode  = w[`STS_ARITH_W +: `STS_MODE_W];
          mArith = w[`STS_ARITH_W-1:0];
        end
      end
      default: ;
    endcase
    recordRow(nm, op, data, cond, 1'b0);
  endtask

  task automatic addResetRow(input string nm, input condE cond);
    mArith = '0;
    mMode  = '0;
    mMask  = '0;
    mOvf   = 1'b0;
    stackModel.delete();
    recordRow(nm, OP_NOP, 10'h000, cond, 1'b1);
  endtask

  task automatic compareValue(input string nm, input string field,
                              input logic [31:0] expVal, input logic [31:0] actVal);
    checkCount = checkCount + 1;
    if (actVal !== expVal) begin
      $display("CHECK FAILED %s %s expected %0h actual %0h", nm, field, expVal, actVal);
      errorCount = errorCount + 1;
    end
  endtask

  task automatic checkOutputs(input int r);
    compareValue(rowName[r], "arithStat", 32'(expArith[r]), 32'(arithStat));
    compareValue(rowName[r], "modeStat", 32'(expMode[r]), 32'(modeStat));
    compareValue(rowName[r], "intMask", 32'(expMask[r]), 32'(intMask));
    compareValue(rowName[r], "stack flags", 32'(expFlags[r]),
                 32'({stkFull, stkEmpty, stkHas1, stkOvf}));
  endtask

  initial begin
    STSCLK     = 1'b0;
    T_RST      = 1'b1;
    cmdValid   = 1'b0;
    cmdOp      = OP_NOP;
    cmdData    = '0;
    condSel    = COND_EQ;
    errorCount = 0;
    checkCount = 0;
    cycleCount = 0;
    rowCount   = 0;
    mArith     = '0;
    mMode      = '0;
    mMask      = '0;
    mOvf       = 1'b0;

    addRow("after reset", OP_NOP, 10'h000, COND_EQ);
    addRow("write arith", OP_WRARITH, 10'h0A5, COND_EQ);
    addRow("write mode", OP_WRMODE, 10'h3DA, COND_NE);   // upper bits dropped
    addRow("write mask", OP_WRMASK, 10'h3C3, COND_ALWAYS);
    for (int i = 0; i < `STS_DEPTH; i++) begin
      addRow($sformatf("arith for push %0d", i), OP_WRARITH, 10'(8'h13 * (i + 1)), condE'(i));
      addRow($sformatf("push %0d", i), OP_PUSH, 10'h000, condE'(i + 1));
    end
    addRow("arith before extra push", OP_WRARITH, 10'h0FF, COND_LE);
    addRow("push while full", OP_PUSH, 10'h000, COND_AC);
    for (int i = 0; i < `STS_DEPTH; i++) begin
      addRow($sformatf("pop %0d", i), OP_POP, 10'h000, condE'(10 - i));
    end
    addResetRow("mid-run reset", COND_NE);
    addRow("arith before empty pop", OP_WRARITH, 10'h03C, COND_NOTAV);
    addRow("pop while empty", OP_POP, 10'h000, COND_AV);
    addRow("mask before interrupt", OP_WRMASK, 10'h2B5, COND_EQ);
    addRow("mode before interrupt", OP_WRMODE, 10'h011, COND_EQ);
    addRow("interrupt entry", OP_INTENTRY, 10'h000, COND_GT);
    addRow("arith in handler", OP_WRARITH, 10'h002, COND_LT);
    addRow("return from interrupt", OP_POP, 10'h000, COND_GE);
    for (int k = 0; k < 7; k++) begin
      // zero, each single flag, all flags, spare bits only
      addRow($sformatf("flags %0d", k), OP_WRARITH,
             (k == 0) ? 10'h000 : (k == 5) ? 10'h00F : (k == 6) ? 10'h0F0 : 10'(1 << (k - 1)),
             COND_EQ);
      for (int c = 1; c <= 10; c++) begin
        addRow($sformatf("flags %0d cond %0d", k, c), OP_NOP, 10'h000, condE'(c));
      end
    end
    cycleLimit = rowCount * 5 + 50;

    repeat (3) @(posedge STSCLK);
    @(negedge STSCLK);
    T_RST = 1'b0;

    for (int r = 0; r < rowCount; r++) begin
      condSel = rowCond[r];
      if (rowIsReset[r]) begin
        T_RST = 1'b1;
        repeat (3) @(negedge STSCLK);
        compareValue(rowName[r], "condTrue in reset", 32'd0, 32'(condTrue));
        T_RST = 1'b0;
      end else begin
        cmdValid = 1'b1;
        cmdOp    = rowOp[r];
        cmdData  = rowData[r];
        @(negedge STSCLK);
        cmdValid = 1'b0;
        cmdOp    = OP_NOP;
        cmdData  = '0;
      end
      @(negedge STSCLK);                           // registers settle two cycles after the command
      checkOutputs(r);
      @(negedge STSCLK);
      compareValue(rowName[r], "condTrue", 32'(expCondTrue[r]), 32'(condTrue));
      @(negedge STSCLK);
    end

    $display("rows: %0d, checks: %0d, errors: %0d", rowCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* stsSeq.f */
+incdir+include
rtl/stsTypesPkg.sv
rtl/stsCmdPkg.sv
rtl/stsCmdDecode.sv
rtl/statusRegs.sv
rtl/stackMem.sv
rtl/statusStack.sv
rtl/stsCondEval.sv
rtl/stsSeqTop.sv
bench/stsSeqTb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= stsSeqTb
FILELIST   ?= stsSeq.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= No errors
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
